/* hw/memPkg.sv */
package memPkg;

  // Basic bus widths
  typedef logic [31:0] addrT;
  typedef logic [31:0] wordT;
  typedef logic [3:0]  maskT;
  typedef logic [1:0]  sizeT;

  // Transfer sizes in HSIZE coding
  localparam sizeT sizeByte = 2'd0;
  localparam sizeT sizeHalf = 2'd1;
  localparam sizeT sizeWord = 2'd2;

  // Instruction cache geometry
  localparam int icLines      = 16;
  localparam int icBlockWords = 4;

  localparam int icOffsetBits = $clog2(icBlockWords);
  localparam int icIndexBits  = $clog2(icLines);
  localparam int icIndexLsb   = icOffsetBits + 2;
  localparam int icTagLsb     = icIndexLsb + icIndexBits;
  localparam int icTagBits    = 32 - icTagLsb;

  typedef logic [icOffsetBits-1:0] icOffsetT;
  typedef logic [icIndexBits-1:0]  icIndexT;
  typedef logic [icTagBits-1:0]    icTagT;

  // Bus memory
  localparam int memWords      = 1024;
  localparam int memWaitCycles = 2;
  localparam int memIndexBits  = $clog2(memWords);

  typedef logic [memIndexBits-1:0] memIndexT;

  // Wait counter runs 0 .. memWaitCycles+1
  typedef logic [$clog2(memWaitCycles + 2)-1:0] waitCntT;

  localparam waitCntT memReadyCount = waitCntT'(memWaitCycles + 1);

  // Instruction cache controller
  typedef enum logic [1:0] {
    idle,
    refill,
    respond
  } icStateT;

endpackage

/* hw/instrCache.sv */
`timescale 1ns/1ps

module instrCache (
  input  logic         clk,
  input  logic         arstN,
  input  logic         fetchReq,
  input  logic         cacheEnable,
  input  logic         invalidate,
  input  memPkg::addrT fetchAddr,
  output logic         fetchValid,
  output logic         fetchBusy,
  output memPkg::wordT fetchInstr,
  output logic         icBusReq,
  output memPkg::addrT icBusAddr,
  input  logic         icBusReady,
  input  memPkg::wordT busRdata
);

  memPkg::icStateT state;

  memPkg::icTagT            tagArray  [memPkg::icLines];
  memPkg::wordT             dataArray [memPkg::icLines][memPkg::icBlockWords];
  logic [memPkg::icLines-1:0] validBits;

  // Fields of the fetch in flight
  memPkg::icTagT    reqTag;
  memPkg::icIndexT  reqIndex;
  memPkg::icOffsetT reqOffset;
  memPkg::icOffsetT beat;
  logic             bypass;
  logic             lastBeat;

  memPkg::icTagT    fetchTag;
  memPkg::icIndexT  fetchIndex;
  memPkg::icOffsetT fetchOffset;
  logic             hit;

  assign fetchTag    = fetchAddr[31:memPkg::icTagLsb];
  assign fetchIndex  = fetchAddr[memPkg::icTagLsb-1:memPkg::icIndexLsb];
  assign fetchOffset = fetchAddr[memPkg::icIndexLsb-1:2];

  assign hit = cacheEnable && validBits[fetchIndex] && (tagArray[fetchIndex] == fetchTag);

  assign lastBeat = beat == memPkg::icOffsetT'(memPkg::icBlockWords - 1);

  assign fetchBusy  = state != memPkg::idle;
  assign fetchValid = state == memPkg::respond;
  assign icBusReq   = state == memPkg::refill;

  // Uncached fetch reads just the requested word
  assign icBusAddr = {reqTag, reqIndex, bypass ? reqOffset : beat, 2'b00};

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      state     <= memPkg::idle;
      validBits <= '0;
      beat      <= '0;
      bypass    <= 1'b0;
    end
    else
    begin
      if (invalidate)
        validBits <= '0;
      case (state)
        memPkg::idle:
        begin
          if (fetchReq)
          begin
            beat   <= '0;
            bypass <= !cacheEnable;
            state  <= hit ? memPkg::respond : memPkg::refill;
            // Line is rewritten from beat 0 on
            if (cacheEnable && !hit)
              validBits[fetchIndex] <= 1'b0;
          end
        end
        memPkg::refill:
        begin
          if (icBusReady)
          begin
            beat <= beat + 1'b1;
            if (bypass || lastBeat)
              state <= memPkg::respond;
            if (!bypass && lastBeat)
              validBits[reqIndex] <= 1'b1;
          end
        end
        default:
          state <= memPkg::idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == memPkg::idle && fetchReq)
    begin
      reqTag     <= fetchTag;
      reqIndex   <= fetchIndex;
      reqOffset  <= fetchOffset;
      fetchInstr <= dataArray[fetchIndex][fetchOffset];
    end
    if (state == memPkg::refill && icBusReady)
    begin
      if (!bypass)
        dataArray[reqIndex][beat] <= busRdata;
      if (!bypass && lastBeat)
        tagArray[reqIndex] <= reqTag;
      // Requested word passes on to the core as it arrives
      if (bypass || beat == reqOffset)
        fetchInstr <= busRdata;
    end
  end

  // Core strobes only when the cache is free
  noFetchWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
    fetchReq |-> !fetchBusy);

  noInvalidateInRefill: assert property (@(posedge clk) disable iff (!arstN)
    invalidate |-> state != memPkg::refill);

endmodule

/* hw/dataPort.sv */
`timescale 1ns/1ps

module dataPort (
  input  logic         clk,
  input  logic         arstN,
  input  logic         dataReq,
  input  logic         dataWrite,
  input  memPkg::addrT dataAddr,
  input  memPkg::wordT dataWdata,
  input  memPkg::maskT dataMask,
  output logic         dataValid,
  output logic         dataBusy,
  output memPkg::wordT dataRdata,
  output logic         dpBusReq,
  output logic         dpBusWrite,
  output memPkg::addrT dpBusAddr,
  output memPkg::sizeT dpBusSize,
  output memPkg::wordT dpBusWdata,
  input  logic         dpBusReady,
  input  memPkg::wordT busRdata
);

  logic         pending;
  logic         validQ;
  logic         writeQ;
  memPkg::addrT addrQ;
  memPkg::sizeT sizeQ;
  memPkg::wordT wdataQ;

  memPkg::sizeT reqSize;
  logic [1:0]   reqLane;

  // Size and lowest enabled lane from the byte mask
  always_comb
  begin
    case (dataMask)
      4'b1111: reqSize = memPkg::sizeWord;
      4'b0011, 4'b1100: reqSize = memPkg::sizeHalf;
      default: reqSize = memPkg::sizeByte;
    endcase
    if (dataMask[0])
      reqLane = 2'd0;
    else if (dataMask[1])
      reqLane = 2'd1;
    else if (dataMask[2])
      reqLane = 2'd2;
    else
      reqLane = 2'd3;
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      pending <= 1'b0;
      validQ  <= 1'b0;
    end
    else
    begin
      validQ <= pending && dpBusReady;
      if (dataReq)
        pending <= 1'b1;
      else if (dpBusReady)
        pending <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (dataReq)
    begin
      writeQ <= dataWrite;
      addrQ  <= {dataAddr[31:2], reqLane};
      sizeQ  <= reqSize;
      wdataQ <= dataWdata;
    end
    if (pending && dpBusReady && !writeQ)
      dataRdata <= busRdata;
  end

  assign dataValid  = validQ;
  assign dataBusy   = pending || validQ;
  assign dpBusReq   = pending;
  assign dpBusWrite = writeQ;
  assign dpBusAddr  = addrQ;
  assign dpBusSize  = sizeQ;
  assign dpBusWdata = wdataQ;

  noDataWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
    dataReq |-> !dataBusy);

  // One byte, an aligned halfword or the whole word
  legalMask: assert property (@(posedge clk) disable iff (!arstN)
    dataReq |-> dataMask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                 4'b0011, 4'b1100, 4'b1111});

endmodule

/* hw/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
  input  logic         clk,
  input  logic         arstN,
  input  logic         icBusReq,
  input  memPkg::addrT icBusAddr,
  output logic         icBusReady,
  input  logic         dpBusReq,
  input  logic         dpBusWrite,
  input  memPkg::addrT dpBusAddr,
  input  memPkg::sizeT dpBusSize,
  input  memPkg::wordT dpBusWdata,
  output logic         dpBusReady,
  output logic         busReq,
  output logic         busWrite,
  output memPkg::addrT busAddr,
  output memPkg::sizeT busSize,
  output memPkg::wordT busWdata,
  input  logic         busReady
);

  logic grantIc;
  logic grantDp;

  // Grant is held until the transfer's ready
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      grantIc <= 1'b0;
      grantDp <= 1'b0;
    end
    else if (grantIc || grantDp)
    begin
      if (busReady)
      begin
        grantIc <= 1'b0;
        grantDp <= 1'b0;
      end
    end
    // Data side first
    else if (dpBusReq)
      grantDp <= 1'b1;
    else if (icBusReq)
      grantIc <= 1'b1;
  end

  assign busReq   = grantDp ? dpBusReq : (grantIc && icBusReq);
  assign busAddr  = grantDp ? dpBusAddr : icBusAddr;
  assign busWrite = grantDp && dpBusWrite;
  assign busSize  = grantDp ? dpBusSize : memPkg::sizeWord;
  assign busWdata = grantDp ? dpBusWdata : '0;

  assign icBusReady = grantIc && busReady;
  assign dpBusReady = grantDp && busReady;

  // Granted side keeps its request until ready
  grantedReqHeld: assert property (@(posedge clk) disable iff (!arstN)
    (grantDp || grantIc) |-> busReq);

endmodule

/* hw/busMemory.sv */
`timescale 1ns/1ps

module busMemory (
  input  logic         clk,
  input  logic         arstN,
  input  logic         busReq,
  input  logic         busWrite,
  input  memPkg::addrT busAddr,
  input  memPkg::sizeT busSize,
  input  memPkg::wordT busWdata,
  output memPkg::wordT busRdata,
  output logic         busReady
);

  memPkg::wordT     mem [memPkg::memWords];
  memPkg::waitCntT  waitCnt;
  memPkg::memIndexT wordIdx;
  memPkg::maskT     laneEn;

  // Upper address bits alias onto the array
  assign wordIdx = busAddr[memPkg::memIndexBits+1:2];

  assign busReady = busReq && (waitCnt == memPkg::memReadyCount);

  // Byte enables from size and low address bits
  always_comb
  begin
    case (busSize)
      memPkg::sizeByte: laneEn = memPkg::maskT'(1) << busAddr[1:0];
      memPkg::sizeHalf: laneEn = busAddr[1] ? 4'b1100 : 4'b0011;
      default: laneEn = 4'b1111;
    endcase
  end

  // Counts cycles since busReq was first seen
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      waitCnt <= '0;
    else if (!busReq || busReady)
      waitCnt <= '0;
    else
      waitCnt <= waitCnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (busReady && busWrite)
    begin
      for (int lane = 0; lane < 4; lane++)
      begin
        if (laneEn[lane])
          mem[wordIdx][8*lane +: 8] <= busWdata[8*lane +: 8];
      end
    end
    // Read one cycle early so data lines up with ready
    if (busReq && !busWrite && waitCnt == memPkg::waitCntT'(memPkg::memWaitCycles))
      busRdata <= mem[wordIdx];
  end

  // Master holds the request and its fields until ready
  reqHeldUntilReady: assert property (@(posedge clk) disable iff (!arstN)
    busReq && !busReady |=> busReq && $stable(busAddr) && $stable(busWrite));

endmodule

/* hw/memSystem.sv */
`timescale 1ns/1ps

module memSystem (
  input  logic         clk,
  input  logic         arstN,
  input  logic         fetchReq,
  input  memPkg::addrT fetchAddr,
  output logic         fetchValid,
  output logic         fetchBusy,
  output memPkg::wordT fetchInstr,
  input  logic         dataReq,
  input  logic         dataWrite,
  input  memPkg::addrT dataAddr,
  input  memPkg::wordT dataWdata,
  input  memPkg::maskT dataMask,
  output logic         dataValid,
  output logic         dataBusy,
  output memPkg::wordT dataRdata,
  input  logic         cacheEnable,
  input  logic         invalidate
);

  // Requester side of the arbiter
  logic         icBusReq, icBusReady;
  memPkg::addrT icBusAddr;
  logic         dpBusReq, dpBusWrite, dpBusReady;
  memPkg::addrT dpBusAddr;
  memPkg::sizeT dpBusSize;
  memPkg::wordT dpBusWdata;

  // Arbiter to memory
  logic         busReq, busWrite, busReady;
  memPkg::addrT busAddr;
  memPkg::sizeT busSize;
  memPkg::wordT busWdata, busRdata;

  instrCache instrCache (
    .clk        (clk        ),
    .arstN      (arstN      ),
    .fetchReq   (fetchReq   ),
    .cacheEnable(cacheEnable),
    .invalidate (invalidate ),
    .fetchAddr  (fetchAddr  ),
    .fetchValid (fetchValid ),
    .fetchBusy  (fetchBusy  ),
    .fetchInstr (fetchInstr ),
    .icBusReq   (icBusReq   ),
    .icBusAddr  (icBusAddr  ),
    .icBusReady (icBusReady ),
    .busRdata   (busRdata   )
  );

  dataPort dataPort (
    .clk       (clk       ),
    .arstN     (arstN     ),
    .dataReq   (dataReq   ),
    .dataWrite (dataWrite ),
    .dataAddr  (dataAddr  ),
    .dataWdata (dataWdata ),
    .dataMask  (dataMask  ),
    .dataValid (dataValid ),
    .dataBusy  (dataBusy  ),
    .dataRdata (dataRdata ),
    .dpBusReq  (dpBusReq  ),
    .dpBusWrite(dpBusWrite),
    .dpBusAddr (dpBusAddr ),
    .dpBusSize (dpBusSize ),
    .dpBusWdata(dpBusWdata),
    .dpBusReady(dpBusReady),
    .busRdata  (busRdata  )
  );

  busArbiter busArbiter (
    .clk       (clk       ),
    .arstN     (arstN     ),
    .icBusReq  (icBusReq  ),
    .icBusAddr (icBusAddr ),
    .icBusReady(icBusReady),
    .dpBusReq  (dpBusReq  ),
    .dpBusWrite(dpBusWrite),
    .dpBusAddr (dpBusAddr ),
    .dpBusSize (dpBusSize ),
    .dpBusWdata(dpBusWdata),
    .dpBusReady(dpBusReady),
    .busReq    (busReq    ),
    .busWrite  (busWrite  ),
    .busAddr   (busAddr   ),
    .busSize   (busSize   ),
    .busWdata  (busWdata  ),
    .busReady  (busReady  )
  );

  busMemory busMemory (
    .clk     (clk     ),
    .arstN   (arstN   ),
    .busReq  (busReq  ),
    .busWrite(busWrite),
    .busAddr (busAddr ),
    .busSize (busSize ),
    .busWdata(busWdata),
    .busRdata(busRdata),
    .busReady(busReady)
  );

endmodule

/* dv/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic arstN
);

  localparam int halfPeriod  = 50;
  localparam int resetCycles = 10;

  initial
  begin
    clk = 1'b0;
    forever
      #halfPeriod clk = ~clk;
  end

  initial
  begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    arstN <= 1'b1;
  end

endmodule

/* dv/memSystemTb.sv */
`timescale 1ns/1ps

module memSystemTb;

  localparam int timeoutCycles = 200;

  typedef enum logic [2:0] {
    opWrite, opRead, opFetch, opInvalidate, opEnable, opDisable, opDual
  } opT;

  // Table row with the extra fetch fields of dual rows
  typedef struct packed {
    opT           op;
    memPkg::addrT addr;
    memPkg::wordT data;
    memPkg::maskT mask;
    memPkg::wordT expWord;
    memPkg::addrT fetchAt;
    memPkg::wordT expFetch;
    logic         hitCheck;
  } stepT;

  logic         clk, arstN;
  logic         fetchReq, fetchValid, fetchBusy;
  memPkg::addrT fetchAddr;
  memPkg::wordT fetchInstr;
  logic         dataReq, dataWrite, dataValid, dataBusy;
  memPkg::addrT dataAddr;
  memPkg::wordT dataWdata, dataRdata;
  memPkg::maskT dataMask;
  logic         cacheEnable, invalidate;

  stepT         steps[$];
  memPkg::wordT model[memPkg::addrT];
  integer       seed;
  int           errors;
  int           checks;
  logic         timedOut;

  clockGen clockGen (.clk(clk), .arstN(arstN));

  memSystem dut (
    .clk(clk), .arstN(arstN),
    .fetchReq(fetchReq), .fetchAddr(fetchAddr), .fetchValid(fetchValid),
    .fetchBusy(fetchBusy), .fetchInstr(fetchInstr),
    .dataReq(dataReq), .dataWrite(dataWrite), .dataAddr(dataAddr),
    .dataWdata(dataWdata), .dataMask(dataMask), .dataValid(dataValid),
    .dataBusy(dataBusy), .dataRdata(dataRdata),
    .cacheEnable(cacheEnable), .invalidate(invalidate)
  );

  // Old word with the masked lanes of the new word
  function automatic memPkg::wordT mergeLanes(input memPkg::wordT oldWord,
                                              input memPkg::wordT newWord,
                                              input memPkg::maskT mask);
    memPkg::wordT result;
    result = oldWord;
    for (int lane = 0; lane < 4; lane++)
    begin
      if (mask[lane])
        result[8*lane +: 8] = newWord[8*lane +: 8];
    end
    return result;
  endfunction

  task automatic addStep(input opT op, input memPkg::addrT addr, input memPkg::wordT data,
                         input memPkg::maskT mask, input memPkg::wordT expWord,
                         input logic hitCheck);
    stepT s;
    s          = '0;
    s.op       = op;
    s.addr     = addr;
    s.data     = data;
    s.mask     = mask;
    s.expWord  = expWord;
    s.hitCheck = hitCheck;
    steps.push_back(s);
  endtask

  task automatic addWrite(input memPkg::addrT addr, input memPkg::maskT mask);
    memPkg::wordT data;
    memPkg::wordT oldWord;
    data    = $random(seed);
    oldWord = model.exists(addr) ? model[addr] : '0;
    model[addr] = (mask == 4'b1111) ? data : mergeLanes(oldWord, data, mask);
    addStep(opWrite, addr, data, mask, model[addr], 1'b0);
  endtask

  task automatic addDual(input memPkg::addrT readAt, input memPkg::addrT fetchAt);
    stepT s;
    s          = '0;
    s.op       = opDual;
    s.addr     = readAt;
    s.mask     = 4'b1111;
    s.expWord  = model[readAt];
    s.fetchAt  = fetchAt;
    s.expFetch = model[fetchAt];
    steps.push_back(s);
  endtask

  task automatic buildTable();
    memPkg::wordT staleWord;
    for (int i = 0; i < 8; i++)
      addWrite(32'h100 + 4 * i, 4'b1111);
    for (int i = 0; i < 8; i++)
      addStep(opRead, 32'h100 + 4 * i, '0, 4'b1111, model[32'h100 + 4 * i], 1'b0);
    // Byte and halfword lanes
    addWrite(32'h104, 4'b0001);
    addWrite(32'h108, 4'b0100);
    addWrite(32'h10c, 4'b0010);
    addWrite(32'h110, 4'b1100);
    addWrite(32'h114, 4'b0011);
    addWrite(32'h118, 4'b1000);
    for (int i = 1; i < 7; i++)
      addStep(opRead, 32'h100 + 4 * i, '0, 4'b1111, model[32'h100 + 4 * i], 1'b0);
    addStep(opEnable, '0, '0, '0, '0, 1'b0);
    addStep(opFetch, 32'h100, '0, '0, model[32'h100], 1'b0);
    addStep(opFetch, 32'h104, '0, '0, model[32'h104], 1'b1);
    // Cache keeps the stale word until invalidate
    staleWord = model[32'h108];
    addWrite(32'h108, 4'b1111);
    addStep(opFetch, 32'h108, '0, '0, staleWord, 1'b1);
    addStep(opInvalidate, '0, '0, '0, '0, 1'b0);
    addStep(opFetch, 32'h108, '0, '0, model[32'h108], 1'b0);
    addStep(opDisable, '0, '0, '0, '0, 1'b0);
    addWrite(32'h10c, 4'b1111);
    addStep(opFetch, 32'h10c, '0, '0, model[32'h10c], 1'b0);
    addStep(opEnable, '0, '0, '0, '0, 1'b0);
    addWrite(32'h300, 4'b1111);
    addDual(32'h110, 32'h300);
  endtask

  task automatic checkWord(input string name, input memPkg::wordT got,
                           input memPkg::wordT exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
    else
      $display("Pass at %0t ns: %s is %h", $time, name, got);
  endtask

  task automatic checkLatency(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s is %0d cycles, expected %0d", $time, name, got, exp);
    end
    else
      $display("Pass at %0t ns: %s is %0d cycles", $time, name, got);
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
    else
      $display("Pass at %0t ns: %s is %b", $time, name, got);
  endtask

  // Issues the requests on one edge and counts falling edges until each valid
  task automatic runAccess(input stepT s, input logic doData, input logic doFetch,
                           output memPkg::wordT gotData, output memPkg::wordT gotFetch,
                           output int latency);
    logic dataDone;
    logic fetchDone;
    logic dataBusyHeld;
    logic fetchBusyHeld;
    dataDone      = !doData;
    fetchDone     = !doFetch;
    dataBusyHeld  = 1'b1;
    fetchBusyHeld = 1'b1;
    gotData       = '0;
    gotFetch      = '0;
    latency       = 0;
    @(posedge clk);
    dataReq   <= doData;
    dataWrite <= s.op == opWrite;
    dataAddr  <= s.addr;
    dataWdata <= s.data;
    dataMask  <= s.mask;
    fetchReq  <= doFetch;
    fetchAddr <= (s.op == opDual) ? s.fetchAt : s.addr;
    @(posedge clk);
    dataReq  <= 1'b0;
    fetchReq <= 1'b0;
    for (int n = 1; n <= timeoutCycles; n++)
    begin
      @(negedge clk);
      // Busy covers every cycle up to and including valid
      if (!dataDone)
        dataBusyHeld = dataBusyHeld && dataBusy;
      if (!fetchDone)
        fetchBusyHeld = fetchBusyHeld && fetchBusy;
      if (!dataDone && dataValid)
      begin
        dataDone = 1'b1;
        gotData  = dataRdata;
      end
      if (!fetchDone && fetchValid)
      begin
        fetchDone = 1'b1;
        gotFetch  = fetchInstr;
        latency   = n;
      end
      if (dataDone && fetchDone)
        break;
    end
    if (!(dataDone && fetchDone))
    begin
      timedOut = 1'b1;
      errors++;
      $display("Timeout at %0t ns: no valid strobe within %0d cycles", $time, timeoutCycles);
    end
    else
    begin
      if (doData)
        checkFlag("dataBusy until dataValid", dataBusyHeld, 1'b1);
      if (doFetch)
        checkFlag("fetchBusy until fetchValid", fetchBusyHeld, 1'b1);
    end
  endtask

  task automatic applyControl(input opT op);
    @(posedge clk);
    case (op)
      opEnable: cacheEnable <= 1'b1;
      opDisable: cacheEnable <= 1'b0;
      default: invalidate <= 1'b1;
    endcase
    @(posedge clk);
    invalidate <= 1'b0;
    $display("Done at %0t ns: control step %s", $time, op.name());
  endtask

  initial
  begin
    stepT         s;
    memPkg::wordT gotData;
    memPkg::wordT gotFetch;
    int           latency;
    fetchReq    = 1'b0;
    fetchAddr   = '0;
    dataReq     = 1'b0;
    dataWrite   = 1'b0;
    dataAddr    = '0;
    dataWdata   = '0;
    dataMask    = '0;
    cacheEnable = 1'b0;
    invalidate  = 1'b0;
    seed        = 32'h234e;
    errors      = 0;
    checks      = 0;
    timedOut    = 1'b0;
    buildTable();
    for (int n = 0; n < 50 && !arstN; n++)
      @(posedge clk);
    if (!arstN)
    begin
      timedOut = 1'b1;
      errors++;
      $display("Reset was never released");
    end
    for (int i = 0; i < steps.size() && !timedOut; i++)
    begin
      s = steps[i];
      case (s.op)
        opWrite:
        begin
          runAccess(s, 1'b1, 1'b0, gotData, gotFetch, latency);
          $display("Done at %0t ns: write %h mask %b", $time, s.addr, s.mask);
        end
        opRead:
        begin
          runAccess(s, 1'b1, 1'b0, gotData, gotFetch, latency);
          checkWord($sformatf("dataRdata @%h", s.addr), gotData, s.expWord);
        end
        opFetch:
        begin
          runAccess(s, 1'b0, 1'b1, gotData, gotFetch, latency);
          checkWord($sformatf("fetchInstr @%h", s.addr), gotFetch, s.expWord);
          if (s.hitCheck)
            checkLatency($sformatf("hit latency @%h", s.addr), latency, 1);
        end
        opDual:
        begin
          runAccess(s, 1'b1, 1'b1, gotData, gotFetch, latency);
          checkWord($sformatf("dataRdata @%h", s.addr), gotData, s.expWord);
          checkWord($sformatf("fetchInstr @%h", s.fetchAt), gotFetch, s.expFetch);
        end
        default:
          applyControl(s.op);
      endcase
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* sim.f */
hw/memPkg.sv
hw/instrCache.sv
hw/dataPort.sv
hw/busArbiter.sv
hw/busMemory.sv
hw/memSystem.sv
dv/clockGen.sv
dv/memSystemTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= memSystemTb
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(shell cat $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)
PASS_TEXT := Finished with no errors

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
